// File: Bender.yml
package:
  name: evict_path

sources:
  - src/evict_pkg.sv
  - src/evict_cfg_regs.sv
  - src/eviction_write_buffer.sv
  - src/line_store.sv
  - src/evict_path_top.sv
  - target: test
    files:
      - verification/evict_path_checker.sv
      - verification/evict_path_tb.sv

// File: evict_path.f
src/evict_pkg.sv
src/evict_cfg_regs.sv
src/eviction_write_buffer.sv
src/line_store.sv
src/evict_path_top.sv
verification/evict_path_checker.sv
verification/evict_path_tb.sv

// File: src/evict_cfg_regs.sv
`timescale 1ns/100ps
`default_nettype none

module evict_cfg_regs
(
	input  wire                                 clk,
	input  wire                                 rst_n,

	input  wire evict_pkg::cfg_sel_e            cfg_sel,
	input  wire                                 cfg_write,
	input  wire [evict_pkg::CNT_BITS-1:0]       cfg_wdata,
	output logic [evict_pkg::CNT_BITS-1:0]      cfg_rdata,

	input  wire                                 hit_pulse,
	input  wire                                 drain_pulse,
	output logic [evict_pkg::CNT_BITS-1:0]      hold_time
);

	logic [evict_pkg::CNT_BITS-1:0] hold_q;
	logic [evict_pkg::CNT_BITS-1:0] hits_q;
	logic [evict_pkg::CNT_BITS-1:0] drains_q;

	assign hold_time = hold_q;

	always_ff @(posedge clk)
	begin : reg_update
		if (!rst_n)
		begin
			hold_q   <= evict_pkg::HOLD_DEFAULT;
			hits_q   <= '0;
			drains_q <= '0;
		end
		else
		begin
			if (cfg_write && cfg_sel == evict_pkg::CFG_HOLD)
				hold_q <= cfg_wdata;

			// a clear wins over a pulse in the same cycle.
			if (cfg_write && cfg_sel == evict_pkg::CFG_HITS)
				hits_q <= '0;
			else if (hit_pulse && !(&hits_q))
				hits_q <= hits_q + 1'b1;

			if (cfg_write && cfg_sel == evict_pkg::CFG_DRAINS)
				drains_q <= '0;
			else if (drain_pulse && !(&drains_q))
				drains_q <= drains_q + 1'b1; // sticks at all ones.
		end
	end

	always_comb
	begin : reg_read
		case (cfg_sel)
			evict_pkg::CFG_HOLD:   cfg_rdata = hold_q;
			evict_pkg::CFG_HITS:   cfg_rdata = hits_q;
			evict_pkg::CFG_DRAINS: cfg_rdata = drains_q;
			default:               cfg_rdata = '0;
		endcase
	end

	// full counters stay full until software clears them.
	a_hits_saturate : assert property (@(posedge clk) disable iff (!rst_n)
		(&hits_q && !(cfg_write && cfg_sel == evict_pkg::CFG_HITS)) |=> &hits_q)
		else $error("hit counter wrapped");

	a_drains_saturate : assert property (@(posedge clk) disable iff (!rst_n)
		(&drains_q && !(cfg_write && cfg_sel == evict_pkg::CFG_DRAINS)) |=> &drains_q)
		else $error("drain counter wrapped");

endmodule : evict_cfg_regs

`default_nettype wire

// File: src/evict_path_top.sv
`timescale 1ns/100ps
`default_nettype none

module evict_path_top
(
	input  wire                                  clk,
	input  wire                                  rst_n,

	// L2 side.
	input  wire [evict_pkg::ADDR_BITS-1:0]       address,
	input  wire                                  read,
	input  wire                                  write,
	input  wire [evict_pkg::LINE_BITS-1:0]       wdata,
	output logic [evict_pkg::LINE_BITS-1:0]      rdata,
	output logic                                 resp,

	// configuration port.
	input  wire evict_pkg::cfg_sel_e             cfg_sel,
	input  wire                                  cfg_write,
	input  wire [evict_pkg::CNT_BITS-1:0]        cfg_wdata,
	output logic [evict_pkg::CNT_BITS-1:0]       cfg_rdata
);

	logic [evict_pkg::CNT_BITS-1:0]  hold_time;
	logic                            hit_pulse;
	logic                            drain_pulse;

	logic [evict_pkg::ADDR_BITS-1:0] pmem_address;
	logic                            pmem_read;
	logic                            pmem_write;
	logic [evict_pkg::LINE_BITS-1:0] pmem_wdata;
	logic [evict_pkg::LINE_BITS-1:0] pmem_rdata;
	logic                            pmem_resp;

	evict_cfg_regs u_evict_cfg_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.cfg_sel     (cfg_sel),
		.cfg_write   (cfg_write),
		.cfg_wdata   (cfg_wdata),
		.cfg_rdata   (cfg_rdata),
		.hit_pulse   (hit_pulse),
		.drain_pulse (drain_pulse),
		.hold_time   (hold_time)
	);

	eviction_write_buffer u_eviction_write_buffer (
		.clk          (clk),
		.rst_n        (rst_n),
		.address      (address),
		.read         (read),
		.write        (write),
		.wdata        (wdata),
		.rdata        (rdata),
		.resp         (resp),
		.hold_time    (hold_time),
		.hit_pulse    (hit_pulse),
		.drain_pulse  (drain_pulse),
		.pmem_address (pmem_address),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_wdata   (pmem_wdata),
		.pmem_rdata   (pmem_rdata),
		.pmem_resp    (pmem_resp)
	);

	line_store u_line_store (
		.clk          (clk),
		.rst_n        (rst_n),
		.pmem_address (pmem_address),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_wdata   (pmem_wdata),
		.pmem_rdata   (pmem_rdata),
		.pmem_resp    (pmem_resp)
	);

endmodule : evict_path_top

`default_nettype wire

// File: src/evict_pkg.sv
`default_nettype none

package evict_pkg;

	// address and line geometry.
	localparam int unsigned ADDR_BITS   = 32;
	localparam int unsigned LINE_BITS   = 256;
	localparam int unsigned OFFSET_BITS = 5; // 32 bytes per line.

	// backing store, indexed by the bits just above the offset.
	localparam int unsigned STORE_LINES      = 64;
	localparam int unsigned STORE_INDEX_BITS = $clog2(STORE_LINES);

	// wait cycles inside the store before resp.
	localparam int unsigned MEM_LATENCY = 3;
	localparam int unsigned LAT_BITS    = $clog2(MEM_LATENCY);
	localparam logic [LAT_BITS-1:0] LAT_LAST = LAT_BITS'(MEM_LATENCY - 1);

	// configuration data and counter width.
	localparam int unsigned CNT_BITS = 16;
	localparam logic [CNT_BITS-1:0] HOLD_DEFAULT = 16'd2;

	typedef enum logic [1:0] {
		CFG_HOLD   = 2'd0,
		CFG_HITS   = 2'd1,
		CFG_DRAINS = 2'd2
	} cfg_sel_e;

	typedef enum logic [1:0] {
		BUF_EMPTY = 2'd0,
		BUF_HELD  = 2'd1,
		BUF_DRAIN = 2'd2 // held line going out to memory.
	} buf_state_e;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_WAIT = 2'd1,
		ST_RESP = 2'd2,
		ST_REST = 2'd3
	} store_state_e;

endpackage : evict_pkg

`default_nettype wire

// File: src/eviction_write_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module eviction_write_buffer
(
	input  wire                                  clk,
	input  wire                                  rst_n,

	// L2 side.
	input  wire [evict_pkg::ADDR_BITS-1:0]       address,
	input  wire                                  read,
	input  wire                                  write,
	input  wire [evict_pkg::LINE_BITS-1:0]       wdata,
	output logic [evict_pkg::LINE_BITS-1:0]      rdata,
	output logic                                 resp,

	// configuration and statistics.
	input  wire [evict_pkg::CNT_BITS-1:0]        hold_time,
	output logic                                 hit_pulse,
	output logic                                 drain_pulse,

	// memory side.
	output logic [evict_pkg::ADDR_BITS-1:0]      pmem_address,
	output logic                                 pmem_read,
	output logic                                 pmem_write,
	output logic [evict_pkg::LINE_BITS-1:0]      pmem_wdata,
	input  wire [evict_pkg::LINE_BITS-1:0]       pmem_rdata,
	input  wire                                  pmem_resp
);

	evict_pkg::buf_state_e state;
	evict_pkg::buf_state_e next_state;

	logic [evict_pkg::ADDR_BITS-1:0] held_addr;
	logic [evict_pkg::LINE_BITS-1:0] held_data;
	logic [evict_pkg::CNT_BITS-1:0]  idle_cnt;
	logic                            line_match;

	// same line when everything above the byte offset agrees.
	assign line_match = (address[evict_pkg::ADDR_BITS-1:evict_pkg::OFFSET_BITS] ==
		held_addr[evict_pkg::ADDR_BITS-1:evict_pkg::OFFSET_BITS]);

	always_comb
	begin : state_actions
		rdata        = pmem_rdata;
		resp         = 1'b0;
		hit_pulse    = 1'b0;
		drain_pulse  = 1'b0;
		pmem_address = address;
		pmem_wdata   = held_data;
		pmem_read    = 1'b0;
		pmem_write   = 1'b0;

		case (state)
			evict_pkg::BUF_EMPTY:
			begin
				if (write)
					resp = 1'b1; // line is captured at this edge.
				else if (read)
				begin
					pmem_read = 1'b1;
					resp      = pmem_resp;
				end
			end

			evict_pkg::BUF_HELD:
			begin
				if (read && line_match)
				begin
					rdata     = held_data;
					resp      = 1'b1;
					hit_pulse = 1'b1;
				end
				else if (read)
				begin
					pmem_read = 1'b1;
					resp      = pmem_resp;
				end
			end

			evict_pkg::BUF_DRAIN:
			begin
				pmem_write   = 1'b1;
				pmem_address = held_addr;
				drain_pulse  = pmem_resp;
				// other reads and any new write wait for the drain.
				if (read && line_match)
				begin
					rdata     = held_data;
					resp      = 1'b1;
					hit_pulse = 1'b1;
				end
			end

			default:;
		endcase
	end

	always_comb
	begin : next_state_logic
		next_state = state;

		case (state)
			evict_pkg::BUF_EMPTY:
			begin
				if (write)
					next_state = evict_pkg::BUF_HELD;
			end

			evict_pkg::BUF_HELD:
			begin
				if (write)
					next_state = evict_pkg::BUF_DRAIN;
				else if (!read && idle_cnt >= hold_time)
					next_state = evict_pkg::BUF_DRAIN;
			end

			evict_pkg::BUF_DRAIN:
			begin
				if (pmem_resp)
					next_state = evict_pkg::BUF_EMPTY;
			end

			default: next_state = evict_pkg::BUF_EMPTY;
		endcase
	end

	always_ff @(posedge clk)
	begin : state_regs
		if (!rst_n)
		begin
			state    <= evict_pkg::BUF_EMPTY;
			idle_cnt <= '0;
		end
		else
		begin
			state <= next_state;
			if (state != evict_pkg::BUF_HELD || read || write)
				idle_cnt <= '0;
			else
				idle_cnt <= idle_cnt + 1'b1; // quiet cycle.
		end
	end

	// load only on an accepted write.
	always_ff @(posedge clk)
	begin : line_capture
		if (state == evict_pkg::BUF_EMPTY && write)
		begin
			held_addr <= address;
			held_data <= wdata;
		end
	end

	a_l2_one_request : assert property (@(posedge clk) disable iff (!rst_n)
		!(read && write))
		else $error("L2 raised read and write together");

	a_pmem_one_request : assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write))
		else $error("pmem read and write raised together");

	// a drain holds its address until memory answers.
	a_drain_only : assert property (@(posedge clk) disable iff (!rst_n)
		pmem_write |-> ((state == evict_pkg::BUF_DRAIN) and
		(!pmem_resp |=> (pmem_write && $stable(pmem_address)))))
		else $error("pmem write outside a held drain");

endmodule : eviction_write_buffer

`default_nettype wire

// File: src/line_store.sv
`timescale 1ns/100ps
`default_nettype none

module line_store
(
	input  wire                                  clk,
	input  wire                                  rst_n,

	input  wire [evict_pkg::ADDR_BITS-1:0]       pmem_address,
	input  wire                                  pmem_read,
	input  wire                                  pmem_write,
	input  wire [evict_pkg::LINE_BITS-1:0]       pmem_wdata,
	output logic [evict_pkg::LINE_BITS-1:0]      pmem_rdata,
	output logic                                 pmem_resp
);

	logic [evict_pkg::LINE_BITS-1:0] mem [evict_pkg::STORE_LINES];

	evict_pkg::store_state_e state;
	evict_pkg::store_state_e next_state;

	logic [evict_pkg::LAT_BITS-1:0]         lat_cnt;
	logic [evict_pkg::STORE_INDEX_BITS-1:0] index;
	logic                                   lat_done;

	// upper address bits alias onto the same line.
	assign index     = pmem_address[evict_pkg::OFFSET_BITS +: evict_pkg::STORE_INDEX_BITS];
	assign lat_done  = (lat_cnt == evict_pkg::LAT_LAST);
	assign pmem_resp = (state == evict_pkg::ST_RESP);

	always_comb
	begin : sequencer
		next_state = state;
		case (state)
			evict_pkg::ST_IDLE:
			begin
				if (pmem_read || pmem_write)
					next_state = evict_pkg::ST_WAIT;
			end
			evict_pkg::ST_WAIT:
			begin
				if (lat_done)
					next_state = evict_pkg::ST_RESP;
			end
			evict_pkg::ST_RESP: next_state = evict_pkg::ST_REST;
			evict_pkg::ST_REST: next_state = evict_pkg::ST_IDLE; // request drops here.
			default:            next_state = evict_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin : control_regs
		if (!rst_n)
		begin
			state   <= evict_pkg::ST_IDLE;
			lat_cnt <= '0;
		end
		else
		begin
			state <= next_state;
			if (state == evict_pkg::ST_WAIT && !lat_done)
				lat_cnt <= lat_cnt + 1'b1;
			else
				lat_cnt <= '0;
		end
	end

	always_ff @(posedge clk)
	begin : data_path
		// read data is ready for the resp cycle.
		if (state == evict_pkg::ST_WAIT && lat_done)
			pmem_rdata <= mem[index];

		if (state == evict_pkg::ST_RESP && pmem_write)
			mem[index] <= pmem_wdata;
	end

	a_resp_held_request : assert property (@(posedge clk) disable iff (!rst_n)
		pmem_resp |-> (pmem_read || pmem_write))
		else $error("line store answered without a held request");

endmodule : line_store

`default_nettype wire

// File: verification/evict_path_checker.sv
`timescale 1ns/100ps
`default_nettype none

module evict_path_checker
(
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire [evict_pkg::ADDR_BITS-1:0]      address,
	input  wire                                 read,
	input  wire                                 write,
	input  wire [evict_pkg::LINE_BITS-1:0]      wdata,
	input  wire [evict_pkg::LINE_BITS-1:0]      rdata,
	input  wire                                 resp,
	input  wire evict_pkg::cfg_sel_e            cfg_sel,
	input  wire                                 cfg_write,
	input  wire [evict_pkg::CNT_BITS-1:0]       cfg_wdata,
	input  wire [evict_pkg::CNT_BITS-1:0]       cfg_rdata
);

	logic [evict_pkg::LINE_BITS-1:0] shadow  [evict_pkg::STORE_LINES];
	logic                            written [evict_pkg::STORE_LINES];

	logic                           held_valid;
	int unsigned                    held_line;
	int unsigned                    idle;
	logic                           req_open; // request already seen at an earlier edge.
	logic [evict_pkg::CNT_BITS-1:0] hold_model;
	logic [evict_pkg::CNT_BITS-1:0] hits_model;
	logic [evict_pkg::CNT_BITS-1:0] drains_model;
	int                             errors = 0;

	function automatic int unsigned line_of(input logic [evict_pkg::ADDR_BITS-1:0] a);
		return int'(a >> evict_pkg::OFFSET_BITS);
	endfunction

	// the store aliases lines above its depth.
	function automatic int unsigned slot_of(input logic [evict_pkg::ADDR_BITS-1:0] a);
		return line_of(a) % evict_pkg::STORE_LINES;
	endfunction

	task automatic compare_value(input string name, input logic [255:0] exp,
		input logic [255:0] act);
		if (exp !== act)
		begin
			errors++;
			$display("[FAIL] %s expected %h got %h", name, exp, act);
		end
	endtask

	// compares cfg_rdata with the counter model and with the table value.
	task automatic check_cfg(input logic [evict_pkg::CNT_BITS-1:0] table_exp);
		logic [evict_pkg::CNT_BITS-1:0] model;
		case (cfg_sel)
			evict_pkg::CFG_HOLD:   model = hold_model;
			evict_pkg::CFG_HITS:   model = hits_model;
			evict_pkg::CFG_DRAINS: model = drains_model;
			default:               model = '0;
		endcase
		compare_value("cfg_rdata (model)", 256'(model), 256'(cfg_rdata));
		compare_value("cfg_rdata (table)", 256'(table_exp), 256'(cfg_rdata));
	endtask

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			held_valid   = 1'b0;
			idle         = 0;
			req_open     = 1'b0;
			hold_model   = evict_pkg::HOLD_DEFAULT;
			hits_model   = '0;
			drains_model = '0;
			for (int i = 0; i < evict_pkg::STORE_LINES; i++)
				written[i] = 1'b0;
		end
		else
		begin
			if (cfg_write)
			begin
				case (cfg_sel)
					evict_pkg::CFG_HOLD:   hold_model = cfg_wdata;
					evict_pkg::CFG_HITS:   hits_model = '0;
					evict_pkg::CFG_DRAINS: drains_model = '0;
					default:;
				endcase
			end

			if (write && resp)
			begin
				if (held_valid)
				begin
					errors++;
					$display("write was acknowledged while an earlier line was still held");
				end
				shadow[slot_of(address)]  = wdata;
				written[slot_of(address)] = 1'b1;
				held_valid = 1'b1;
				held_line  = line_of(address);
				idle       = 0;
			end
			else if (write && held_valid)
			begin
				drains_model++; // new eviction pushes the old line out.
				held_valid = 1'b0;
			end
			else if (read)
			begin
				if (!req_open && held_valid && line_of(address) == held_line)
				begin
					hits_model++;
					if (!resp)
					begin
						errors++;
						$display("read of held line was not answered from the buffer");
					end
				end
				else if (!req_open && resp)
				begin
					errors++;
					$display("read of a line not held was answered at once");
				end
				if (resp && written[slot_of(address)])
					compare_value("rdata", shadow[slot_of(address)], rdata);
				idle = 0;
			end
			else if (held_valid)
			begin
				if (idle >= hold_model)
				begin
					drains_model++; // idle long enough.
					held_valid = 1'b0;
				end
				else
					idle++;
			end

			req_open = (read || write) && !resp;
		end
	end

endmodule : evict_path_checker

`default_nettype wire

// File: verification/evict_path_tb.sv
`timescale 1ns/100ps
`default_nettype none

module evict_path_tb;

	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_CFG_WRITE,
		OP_CFG_READ
	} tb_op_e;

	localparam int ENTRIES = 22;
	localparam int TIMEOUT = 50;

	logic                            clk = 1'b0;
	logic                            rst_n = 1'b0;
	logic [evict_pkg::ADDR_BITS-1:0] address = '0;
	logic                            read = 1'b0;
	logic                            write = 1'b0;
	logic [evict_pkg::LINE_BITS-1:0] wdata = '0;
	logic [evict_pkg::LINE_BITS-1:0] rdata;
	logic                            resp;
	evict_pkg::cfg_sel_e             cfg_sel = evict_pkg::CFG_HOLD;
	logic                            cfg_write = 1'b0;
	logic [evict_pkg::CNT_BITS-1:0]  cfg_wdata = '0;
	logic [evict_pkg::CNT_BITS-1:0]  cfg_rdata;

	// stimulus table: op, line or selector, data seed, idle gap, cfg value.
	tb_op_e      t_op   [ENTRIES];
	int unsigned t_line [ENTRIES];
	logic [7:0]  t_seed [ENTRIES];
	int unsigned t_gap  [ENTRIES];
	logic [15:0] t_val  [ENTRIES];

	int  timeouts = 0;
	int  errors_total;
	bit  abort = 1'b0;
	int  idx;

	always #10 clk = ~clk;

	evict_path_top u_evict_path_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.address   (address),
		.read      (read),
		.write     (write),
		.wdata     (wdata),
		.rdata     (rdata),
		.resp      (resp),
		.cfg_sel   (cfg_sel),
		.cfg_write (cfg_write),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata)
	);

	evict_path_checker u_checker (
		.clk       (clk),
		.rst_n     (rst_n),
		.address   (address),
		.read      (read),
		.write     (write),
		.wdata     (wdata),
		.rdata     (rdata),
		.resp      (resp),
		.cfg_sel   (cfg_sel),
		.cfg_write (cfg_write),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata)
	);

	task automatic add_entry(input int i, input tb_op_e op, input int unsigned line,
		input logic [7:0] seed, input int unsigned gap, input logic [15:0] val);
		t_op[i]   = op;
		t_line[i] = line;
		t_seed[i] = seed;
		t_gap[i]  = gap;
		t_val[i]  = val;
	endtask

	task automatic make_line(input logic [7:0] seed, output logic [255:0] d);
		for (int w = 0; w < 8; w++)
			d[w*32 +: 32] = $urandom ^ {4{seed}};
	endtask

	// holds the request until resp, bounded.
	task automatic await_resp(input string what);
		int n;
		n = 0;
		#1;
		while (!resp && n < TIMEOUT)
		begin
			@(negedge clk);
			#1;
			n++;
		end
		if (!resp)
		begin
			timeouts++;
			abort = 1'b1;
			$display("no response to %s within %0d cycles", what, TIMEOUT);
		end
		@(negedge clk);
	endtask

	task automatic apply_entry(input int i);
		logic [255:0] d;
		address = t_line[i] << evict_pkg::OFFSET_BITS;
		case (t_op[i])
			OP_WRITE:
			begin
				make_line(t_seed[i], d);
				wdata = d;
				write = 1'b1;
				await_resp("write");
				write = 1'b0;
			end
			OP_READ:
			begin
				read = 1'b1;
				await_resp("read");
				read = 1'b0;
			end
			OP_CFG_WRITE:
			begin
				cfg_sel   = evict_pkg::cfg_sel_e'(t_line[i]);
				cfg_wdata = t_val[i];
				cfg_write = 1'b1;
				@(negedge clk);
				cfg_write = 1'b0;
			end
			default:
			begin
				cfg_sel = evict_pkg::cfg_sel_e'(t_line[i]);
				#1;
				u_checker.check_cfg(t_val[i]);
				@(negedge clk);
			end
		endcase
		for (int g = 0; g < t_gap[i]; g++)
			@(negedge clk);
	endtask

	initial
	begin
		void'($urandom(32'h5f6d));
		add_entry(0,  OP_WRITE,     1, 8'h11, 0,  0);  // write then hit.
		add_entry(1,  OP_READ,      1, 8'h00, 12, 0);
		add_entry(2,  OP_WRITE,     2, 8'h22, 12, 0);  // idle drain, then miss.
		add_entry(3,  OP_READ,      2, 8'h00, 2,  0);
		add_entry(4,  OP_WRITE,     3, 8'h33, 0,  0);  // back to back evictions.
		add_entry(5,  OP_WRITE,     4, 8'h44, 0,  0);
		add_entry(6,  OP_READ,      3, 8'h00, 0,  0);  // other line while 4 held.
		add_entry(7,  OP_READ,      4, 8'h00, 12, 0);
		add_entry(8,  OP_CFG_READ,  1, 8'h00, 0,  2);
		add_entry(9,  OP_CFG_READ,  2, 8'h00, 0,  4);
		add_entry(10, OP_CFG_WRITE, 0, 8'h00, 0,  20); // longer hold time.
		add_entry(11, OP_WRITE,     5, 8'h55, 6,  0);
		add_entry(12, OP_READ,      5, 8'h00, 0,  0);
		add_entry(13, OP_CFG_READ,  1, 8'h00, 0,  3);
		add_entry(14, OP_CFG_WRITE, 1, 8'h00, 0,  16'hffff);
		add_entry(15, OP_CFG_READ,  1, 8'h00, 30, 0);
		add_entry(16, OP_CFG_READ,  2, 8'h00, 0,  5);
		add_entry(17, OP_CFG_WRITE, 2, 8'h00, 0,  0);
		add_entry(18, OP_CFG_READ,  2, 8'h00, 0,  0);
		add_entry(19, OP_CFG_WRITE, 0, 8'h00, 0,  2);
		add_entry(20, OP_READ,      3, 8'h00, 0,  0);
		add_entry(21, OP_CFG_READ,  0, 8'h00, 0,  2);

		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		idx = 0;
		while (idx < ENTRIES && !abort)
		begin
			apply_entry(idx);
			idx++;
		end

		errors_total = u_checker.errors + timeouts;
		$display("check errors %0d, timeouts %0d", u_checker.errors, timeouts);
		if (errors_total == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule : evict_path_tb

`default_nettype wire
